// File: vlog.f
ooo_pkg.sv
wb_uop_port.sv
issue_slot.sv
alu_unit.sv
mul_pipe.sv
phys_reg_file.sv
ooo_core_top.sv
tb_checker.sv
tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_top \
    -Mdir obj_dir -o tb_top_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb_top.sv
/* Testbench top: clock, reset, Wishbone master tasks, directed and random
   micro-op tests, run limit */
`timescale 1ns/10ps

module tb_top;
    import ooo_pkg::*;

    // Traffic of all tests together sets the run limit
    localparam int UOP_BUDGET  = 300;
    localparam int READ_BUDGET = 400;
    localparam int CYCLE_LIMIT = UOP_BUDGET * (MUL_STAGES + 6) + READ_BUDGET * 3 + 1000;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] status_word;
    int          seed;
    int          cycles;
    int          sent;
    int          error_count;
    int          check_count;
    int          uop_count;
    int          extra_errors;
    int          extra_checks;
    int          errors_before;

    always #5 clk = ~clk;

    ooo_core_top u_ooo_core_top (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    tb_checker u_tb_checker (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .error_count, .check_count, .uop_count
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // Entered and left at a falling edge with one idle cycle after the ack
    task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_uop(input op_t op, input int rd, input int rs1, input int rs2,
                             input int imm);
        logic [31:0] word;
        logic [31:0] unused;
        word = {op, rd[4:0], rs1[4:0], rs2[4:0], imm[13:0]};
        bus_xfer(1'b1, ADR_UOP, word, unused);
        sent++;
    endtask

    task automatic read_value(input int n);
        logic [31:0] data;
        bus_xfer(1'b0, ADR_VALUE_BASE + n[7:0], '0, data);
    endtask

    task automatic read_status(input int n, output logic [31:0] data);
        bus_xfer(1'b0, ADR_STATUS_BASE + n[7:0], '0, data);
    endtask

    task automatic poll_until_idle(input int n);
        do begin
            read_status(n, status_word);
        end while (status_word[STATUS_PEND_BIT]);
    endtask

    task automatic check_range(input int first, input int last);
        for (int n = first; n <= last; n++) begin
            poll_until_idle(n);
            read_value(n);
        end
    endtask

    // The load-immediate enters the slot only after every older micro-op
    // has dispatched, and r31 clears once it has written back
    task automatic drain_pipeline();
        write_uop(OP_LI, 31, 0, 0, 'h155);
        poll_until_idle(31);
    endtask

    task automatic random_uops(input int count);
        int word;
        int op_sel;
        for (int i = 0; i < count; i++) begin
            word   = $random(seed);
            op_sel = (word & 32'h7fff_ffff) % 5;
            write_uop(op_t'(op_sel[2:0]), (word >> 8) & 31, (word >> 13) & 31,
                      (word >> 18) & 31, $random(seed));
        end
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = error_count + extra_errors;
        $display("[%s] finished with %0d new errors", name, now_errors - errors_before);
        errors_before = now_errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        seed = 32'h1feb_078e;
        cycles = 0;
        sent = 0;
        extra_errors = 0;
        extra_checks = 0;
        errors_before = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < PREG_COUNT; n++) begin
            read_value(n);
            read_status(n, status_word);
        end
        end_test("reset state");

        write_uop(OP_LI, 1, 0, 0, 5);
        write_uop(OP_LI, 2, 0, 0, -3);
        write_uop(OP_ADD, 3, 1, 2, 0);
        write_uop(OP_SUB, 4, 3, 1, 0);
        write_uop(OP_XOR, 5, 4, 3, 0);
        write_uop(OP_ADD, 6, 5, 5, 0);
        write_uop(OP_SUB, 7, 6, 2, 0);
        write_uop(OP_XOR, 1, 1, 7, 0);
        write_uop(OP_LI, 2, 0, 0, 8191);
        write_uop(OP_ADD, 8, 2, 1, 0);
        drain_pipeline();
        check_range(1, 8);
        end_test("alu chains");

        write_uop(OP_LI, 10, 0, 0, 1234);
        write_uop(OP_LI, 11, 0, 0, -77);
        write_uop(OP_MUL, 12, 10, 11, 0);
        write_uop(OP_ADD, 13, 12, 10, 0);
        write_uop(OP_MUL, 14, 12, 12, 0);
        write_uop(OP_LI, 14, 0, 0, 9);
        write_uop(OP_SUB, 15, 14, 13, 0);
        drain_pipeline();
        check_range(10, 15);
        end_test("mul dependents");

        write_uop(OP_LI, 16, 0, 0, 3);
        write_uop(OP_LI, 17, 0, 0, 1000);
        write_uop(OP_LI, 18, 0, 0, -5);
        write_uop(OP_MUL, 19, 16, 17, 0);
        write_uop(OP_ADD, 20, 16, 17, 0);
        write_uop(OP_MUL, 21, 17, 18, 0);
        write_uop(OP_XOR, 22, 16, 18, 0);
        write_uop(OP_MUL, 23, 18, 18, 0);
        write_uop(OP_SUB, 24, 17, 16, 0);
        drain_pipeline();
        check_range(16, 24);
        end_test("mul pipelining");

        // Dependent chain that keeps the slot full and stalls the host writes
        write_uop(OP_LI, 25, 0, 0, 7);
        for (int i = 0; i < 10; i++) begin
            write_uop((i % 3 == 2) ? OP_ADD : OP_MUL, 26 + i % 4, 25 + i % 4, 25, 0);
        end
        drain_pipeline();
        check_range(25, 30);
        if (uop_count != sent) begin
            $display("Lost micro-op: host wrote %0d, checker saw %0d accepted", sent, uop_count);
            extra_errors++;
        end else begin
            extra_checks++;
        end
        end_test("write burst");

        random_uops(200);
        drain_pipeline();
        check_range(0, 31);
        end_test("random micro-ops");

        $display("checks passed: %0d, errors: %0d", check_count + extra_checks,
                 error_count + extra_errors);
        if (error_count + extra_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb_checker.sv
/* Testbench checker: Wishbone monitor with a shadow register model
   that compares every read reply */
`timescale 1ns/10ps

module tb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack,
    output int          error_count,
    output int          check_count,
    output int          uop_count
);
    import ooo_pkg::*;

    logic [DATA_W-1:0] shadow_value [PREG_COUNT];
    logic [TAG_W-1:0]  shadow_tag   [PREG_COUNT];
    logic              req_we;
    logic [ADR_W-1:0]  req_adr;
    logic [DATA_W-1:0] req_dat;
    logic [DATA_W-1:0] expected;
    logic [PREG_W-1:0] idx;

    // Result of one micro-op, taken in program order
    function automatic logic [31:0] ref_result(input op_t op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [13:0] imm);
        logic [31:0] res;
        case (op)
            OP_LI:   res = {{18{imm[13]}}, imm};
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_XOR:  res = a ^ b;
            OP_MUL:  res = a * b;
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s read of r%0d returned %h, expected %h",
                     $time, what, idx, got, exp);
            error_count++;
        end else begin
            check_count++;
        end
    endtask

    task automatic apply_uop(input logic [31:0] word);
        op_t        op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        op  = op_t'(word[UOP_OP_LSB +: 3]);
        rd  = word[UOP_RD_LSB +: 5];
        rs1 = word[UOP_RS1_LSB +: 5];
        rs2 = word[UOP_RS2_LSB +: 5];
        shadow_value[rd] = ref_result(op, shadow_value[rs1], shadow_value[rs2], word[13:0]);
        // Tag is the micro-op's sequence number modulo 8
        shadow_tag[rd] = uop_count[TAG_W-1:0];
        uop_count++;
    endtask

    // Request fields are latched while strobed and used in the ack cycle
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                shadow_value[i] = '0;
                shadow_tag[i]   = '0;
            end
            req_we      = 1'b0;
            req_adr     = '0;
            req_dat     = '0;
            error_count = 0;
            check_count = 0;
            uop_count   = 0;
        end else begin
            if (wb_ack) begin
                idx = req_adr[PREG_W-1:0];
                if (req_we) begin
                    if (req_adr == ADR_UOP) begin
                        apply_uop(req_dat);
                    end
                end else if ((req_adr & 8'he0) == ADR_VALUE_BASE) begin
                    compare("value", wb_dat_r, shadow_value[idx]);
                end else if ((req_adr & 8'he0) == ADR_STATUS_BASE) begin
                    // Before the first micro-op nothing may be pending
                    // Later a pending reply means the host is polling
                    if (!wb_dat_r[STATUS_PEND_BIT] || uop_count == 0) begin
                        expected = '0;
                        expected[TAG_W-1:0] = shadow_tag[idx];
                        compare("status", wb_dat_r, expected);
                    end
                end
            end
            if (wb_cyc && wb_stb) begin
                req_we  = wb_we;
                req_adr = wb_adr;
                req_dat = wb_dat_w;
            end
        end
    end

endmodule

// File: ooo_core_top.sv
/* Top level: Wishbone port, issue slot, ALU, multiplier and register file */
`timescale 1ns/10ps

module ooo_core_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [ooo_pkg::ADR_W-1:0]   wb_adr,
    input  logic [ooo_pkg::DATA_W-1:0]  wb_dat_w,
    output logic [ooo_pkg::DATA_W-1:0]  wb_dat_r,
    output logic                        wb_ack
);
    import ooo_pkg::*;

    logic              uop_valid;
    logic              uop_ready;
    op_t               uop_op;
    logic [PREG_W-1:0] uop_rd;
    logic [PREG_W-1:0] uop_rs1;
    logic [PREG_W-1:0] uop_rs2;
    logic [IMM_W-1:0]  uop_imm;

    logic [PREG_W-1:0] host_preg;
    logic [DATA_W-1:0] host_value;
    logic              host_pending;
    logic [TAG_W-1:0]  host_tag;

    logic [PREG_W-1:0] rs1_preg;
    logic [PREG_W-1:0] rs2_preg;
    logic [PREG_W-1:0] rd_preg;
    logic [DATA_W-1:0] rs1_value;
    logic [DATA_W-1:0] rs2_value;
    logic              rs1_pending;
    logic              rs2_pending;
    logic              rd_pending;
    logic              alloc_en;
    logic [TAG_W-1:0]  alloc_tag;

    logic              alu_start;
    logic              mul_start;
    op_t               ex_op;
    logic [DATA_W-1:0] ex_a;
    logic [DATA_W-1:0] ex_b;
    logic [IMM_W-1:0]  ex_imm;
    logic [PREG_W-1:0] ex_rd;

    logic              alu_wb_valid;
    logic [PREG_W-1:0] alu_wb_preg;
    logic [DATA_W-1:0] alu_wb_value;
    logic              mul_wb_valid;
    logic [PREG_W-1:0] mul_wb_preg;
    logic [DATA_W-1:0] mul_wb_value;

    wb_uop_port u_wb_uop_port (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .uop_valid, .uop_op, .uop_rd, .uop_rs1, .uop_rs2, .uop_imm, .uop_ready,
        .host_preg, .host_value, .host_pending, .host_tag
    );

    issue_slot u_issue_slot (
        .clk, .rst, .uop_valid, .uop_op, .uop_rd, .uop_rs1, .uop_rs2, .uop_imm,
        .uop_ready, .rs1_preg, .rs2_preg, .rd_preg, .rs1_value, .rs1_pending,
        .rs2_value, .rs2_pending, .rd_pending, .alloc_en, .alloc_tag,
        .alu_start, .mul_start, .ex_op, .ex_a, .ex_b, .ex_imm, .ex_rd
    );

    alu_unit u_alu_unit (
        .clk, .rst, .alu_start, .ex_op, .ex_a, .ex_b, .ex_imm, .ex_rd,
        .alu_wb_valid, .alu_wb_preg, .alu_wb_value
    );

    mul_pipe u_mul_pipe (
        .clk, .rst, .mul_start, .ex_a, .ex_b, .ex_rd,
        .mul_wb_valid, .mul_wb_preg, .mul_wb_value
    );

    // The slot's destination read port also names the entry to allocate
    phys_reg_file u_phys_reg_file (
        .clk, .rst, .alloc_en, .alloc_preg(rd_preg), .alloc_tag,
        .alu_wb_valid, .alu_wb_preg, .alu_wb_value,
        .mul_wb_valid, .mul_wb_preg, .mul_wb_value,
        .rs1_preg, .rs2_preg, .rd_preg, .rs1_value, .rs1_pending,
        .rs2_value, .rs2_pending, .rd_pending,
        .host_preg, .host_value, .host_pending, .host_tag
    );

endmodule

// File: phys_reg_file.sv
/* Physical register file with pending bits and tags, two writeback lanes,
   forwarding issue-side read ports and a host read port */
`timescale 1ns/10ps

module phys_reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc_en,
    input  logic [ooo_pkg::PREG_W-1:0]  alloc_preg,
    input  logic [ooo_pkg::TAG_W-1:0]   alloc_tag,
    input  logic                        alu_wb_valid,
    input  logic [ooo_pkg::PREG_W-1:0]  alu_wb_preg,
    input  logic [ooo_pkg::DATA_W-1:0]  alu_wb_value,
    input  logic                        mul_wb_valid,
    input  logic [ooo_pkg::PREG_W-1:0]  mul_wb_preg,
    input  logic [ooo_pkg::DATA_W-1:0]  mul_wb_value,
    input  logic [ooo_pkg::PREG_W-1:0]  rs1_preg,
    input  logic [ooo_pkg::PREG_W-1:0]  rs2_preg,
    input  logic [ooo_pkg::PREG_W-1:0]  rd_preg,
    output logic [ooo_pkg::DATA_W-1:0]  rs1_value,
    output logic                        rs1_pending,
    output logic [ooo_pkg::DATA_W-1:0]  rs2_value,
    output logic                        rs2_pending,
    output logic                        rd_pending,
    input  logic [ooo_pkg::PREG_W-1:0]  host_preg,
    output logic [ooo_pkg::DATA_W-1:0]  host_value,
    output logic                        host_pending,
    output logic [ooo_pkg::TAG_W-1:0]   host_tag
);
    import ooo_pkg::*;

    logic [DATA_W-1:0] value_q   [PREG_COUNT];
    logic              pending_q [PREG_COUNT];
    logic [TAG_W-1:0]  tag_q     [PREG_COUNT];

    // A result on either lane counts as written; ALU lane wins
    function automatic logic [DATA_W-1:0] fwd_value(input logic [PREG_W-1:0] idx);
        logic [DATA_W-1:0] v;
        if (alu_wb_valid && (alu_wb_preg == idx)) begin
            v = alu_wb_value;
        end else if (mul_wb_valid && (mul_wb_preg == idx)) begin
            v = mul_wb_value;
        end else begin
            v = value_q[idx];
        end
        return v;
    endfunction

    function automatic logic fwd_pending(input logic [PREG_W-1:0] idx);
        logic p;
        if (alu_wb_valid && (alu_wb_preg == idx)) begin
            p = 1'b0;
        end else if (mul_wb_valid && (mul_wb_preg == idx)) begin
            p = 1'b0;
        end else begin
            p = pending_q[idx];
        end
        return p;
    endfunction

    always_comb begin
        rs1_value   = fwd_value(rs1_preg);
        rs1_pending = fwd_pending(rs1_preg);
        rs2_value   = fwd_value(rs2_preg);
        rs2_pending = fwd_pending(rs2_preg);
        rd_pending  = fwd_pending(rd_preg);
    end

    // Host sees stored state only
    assign host_value   = value_q[host_preg];
    assign host_pending = pending_q[host_preg];
    assign host_tag     = tag_q[host_preg];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                value_q[i]   <= '0;
                pending_q[i] <= 1'b0;
                tag_q[i]     <= '0;
            end
        end else begin
            if (alu_wb_valid) begin
                value_q[alu_wb_preg]   <= alu_wb_value;
                pending_q[alu_wb_preg] <= 1'b0;
            end
            if (mul_wb_valid) begin
                value_q[mul_wb_preg]   <= mul_wb_value;
                pending_q[mul_wb_preg] <= 1'b0;
            end
            // Allocation last, so a new owner keeps pending over a retiring write
            if (alloc_en) begin
                pending_q[alloc_preg] <= 1'b1;
                tag_q[alloc_preg]     <= alloc_tag;
            end
        end
    end

endmodule

// File: mul_pipe.sv
/* Three-stage pipelined multiplier with valid and destination carried per stage */
`timescale 1ns/10ps

module mul_pipe (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mul_start,
    input  logic [ooo_pkg::DATA_W-1:0]  ex_a,
    input  logic [ooo_pkg::DATA_W-1:0]  ex_b,
    input  logic [ooo_pkg::PREG_W-1:0]  ex_rd,
    output logic                        mul_wb_valid,
    output logic [ooo_pkg::PREG_W-1:0]  mul_wb_preg,
    output logic [ooo_pkg::DATA_W-1:0]  mul_wb_value
);
    import ooo_pkg::*;

    logic              s1_valid;
    logic              s2_valid;
    logic [DATA_W-1:0] s1_a;
    logic [DATA_W-1:0] s1_b;
    logic [DATA_W-1:0] s2_prod;
    logic [PREG_W-1:0] s1_rd;
    logic [PREG_W-1:0] s2_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            mul_wb_valid <= 1'b0;
        end else begin
            s1_valid     <= mul_start;
            s2_valid     <= s1_valid;
            mul_wb_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        // Operand capture
        s1_a  <= ex_a;
        s1_b  <= ex_b;
        s1_rd <= ex_rd;
        // Only the low word of the product is kept
        s2_prod <= s1_a * s1_b;
        s2_rd   <= s1_rd;
        mul_wb_value <= s2_prod;
        mul_wb_preg  <= s2_rd;
    end

endmodule

// File: alu_unit.sv
/* Single-cycle ALU with registered writeback lane */
`timescale 1ns/10ps

module alu_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alu_start,
    input  ooo_pkg::op_t                ex_op,
    input  logic [ooo_pkg::DATA_W-1:0]  ex_a,
    input  logic [ooo_pkg::DATA_W-1:0]  ex_b,
    input  logic [ooo_pkg::IMM_W-1:0]   ex_imm,
    input  logic [ooo_pkg::PREG_W-1:0]  ex_rd,
    output logic                        alu_wb_valid,
    output logic [ooo_pkg::PREG_W-1:0]  alu_wb_preg,
    output logic [ooo_pkg::DATA_W-1:0]  alu_wb_value
);
    import ooo_pkg::*;

    logic [DATA_W-1:0] result;

    always_comb begin
        case (ex_op)
            OP_LI:   result = {{(DATA_W-IMM_W){ex_imm[IMM_W-1]}}, ex_imm};
            OP_ADD:  result = ex_a + ex_b;
            OP_SUB:  result = ex_a - ex_b;
            OP_XOR:  result = ex_a ^ ex_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_preg  <= ex_rd;
        alu_wb_value <= result;
    end

endmodule

// File: issue_slot.sv
/* One-entry issue buffer with operand and destination readiness check,
   tag allocation and dispatch to the ALU or multiplier */
`timescale 1ns/10ps

module issue_slot (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        uop_valid,
    input  ooo_pkg::op_t                uop_op,
    input  logic [ooo_pkg::PREG_W-1:0]  uop_rd,
    input  logic [ooo_pkg::PREG_W-1:0]  uop_rs1,
    input  logic [ooo_pkg::PREG_W-1:0]  uop_rs2,
    input  logic [ooo_pkg::IMM_W-1:0]   uop_imm,
    output logic                        uop_ready,
    output logic [ooo_pkg::PREG_W-1:0]  rs1_preg,
    output logic [ooo_pkg::PREG_W-1:0]  rs2_preg,
    output logic [ooo_pkg::PREG_W-1:0]  rd_preg,
    input  logic [ooo_pkg::DATA_W-1:0]  rs1_value,
    input  logic                        rs1_pending,
    input  logic [ooo_pkg::DATA_W-1:0]  rs2_value,
    input  logic                        rs2_pending,
    input  logic                        rd_pending,
    output logic                        alloc_en,
    output logic [ooo_pkg::TAG_W-1:0]   alloc_tag,
    output logic                        alu_start,
    output logic                        mul_start,
    output ooo_pkg::op_t                ex_op,
    output logic [ooo_pkg::DATA_W-1:0]  ex_a,
    output logic [ooo_pkg::DATA_W-1:0]  ex_b,
    output logic [ooo_pkg::IMM_W-1:0]   ex_imm,
    output logic [ooo_pkg::PREG_W-1:0]  ex_rd
);
    import ooo_pkg::*;

    logic              slot_valid;
    op_t               slot_op;
    logic [PREG_W-1:0] slot_rd;
    logic [PREG_W-1:0] slot_rs1;
    logic [PREG_W-1:0] slot_rs2;
    logic [IMM_W-1:0]  slot_imm;
    logic [TAG_W-1:0]  tag_cnt;
    logic              load;
    logic              srcs_ready;
    logic              dispatch;

    assign uop_ready = !slot_valid;
    assign load      = uop_valid && uop_ready;

    // Read ports look at the held micro-op; results arrive already forwarded
    assign rs1_preg = slot_rs1;
    assign rs2_preg = slot_rs2;
    assign rd_preg  = slot_rd;

    // Load-immediate reads no sources
    assign srcs_ready = (slot_op == OP_LI) || (!rs1_pending && !rs2_pending);

    // Destination still pending means an older write is in flight
    assign dispatch = slot_valid && srcs_ready && !rd_pending;

    assign alloc_en  = dispatch;
    assign alloc_tag = tag_cnt;

    assign alu_start = dispatch && (slot_op != OP_MUL);
    assign mul_start = dispatch && (slot_op == OP_MUL);
    assign ex_op     = slot_op;
    assign ex_a      = rs1_value;
    assign ex_b      = rs2_value;
    assign ex_imm    = slot_imm;
    assign ex_rd     = slot_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
            tag_cnt    <= '0;
        end else begin
            if (load) begin
                slot_valid <= 1'b1;
            end else if (dispatch) begin
                slot_valid <= 1'b0;
            end
            if (dispatch) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            slot_op  <= uop_op;
            slot_rd  <= uop_rd;
            slot_rs1 <= uop_rs1;
            slot_rs2 <= uop_rs2;
            slot_imm <= uop_imm;
        end
    end

endmodule

// File: wb_uop_port.sv
/* Wishbone classic slave: micro-op writes into the issue slot and
   register value and status reads */
`timescale 1ns/10ps

module wb_uop_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [ooo_pkg::ADR_W-1:0]   wb_adr,
    input  logic [ooo_pkg::DATA_W-1:0]  wb_dat_w,
    output logic [ooo_pkg::DATA_W-1:0]  wb_dat_r,
    output logic                        wb_ack,
    output logic                        uop_valid,
    output ooo_pkg::op_t                uop_op,
    output logic [ooo_pkg::PREG_W-1:0]  uop_rd,
    output logic [ooo_pkg::PREG_W-1:0]  uop_rs1,
    output logic [ooo_pkg::PREG_W-1:0]  uop_rs2,
    output logic [ooo_pkg::IMM_W-1:0]   uop_imm,
    input  logic                        uop_ready,
    output logic [ooo_pkg::PREG_W-1:0]  host_preg,
    input  logic [ooo_pkg::DATA_W-1:0]  host_value,
    input  logic                        host_pending,
    input  logic [ooo_pkg::TAG_W-1:0]   host_tag
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_SLOT, ACK} port_state_t;

    port_state_t       state;
    logic              req;
    logic              uop_wr;
    logic              is_value;
    logic              is_status;
    logic [DATA_W-1:0] rd_data;

    // No new request is taken while the ack cycle is on the bus
    assign req    = wb_cyc && wb_stb && (state != ACK);
    assign uop_wr = req && wb_we && (wb_adr == ADR_UOP);

    assign is_value  = wb_adr[ADR_W-1:PREG_W] == ADR_VALUE_BASE[ADR_W-1:PREG_W];
    assign is_status = wb_adr[ADR_W-1:PREG_W] == ADR_STATUS_BASE[ADR_W-1:PREG_W];

    // Master holds the write data, so the fields stay valid until handoff
    assign uop_valid = uop_wr;
    assign uop_op    = op_t'(wb_dat_w[UOP_OP_LSB +: OP_W]);
    assign uop_rd    = wb_dat_w[UOP_RD_LSB +: PREG_W];
    assign uop_rs1   = wb_dat_w[UOP_RS1_LSB +: PREG_W];
    assign uop_rs2   = wb_dat_w[UOP_RS2_LSB +: PREG_W];
    assign uop_imm   = wb_dat_w[UOP_IMM_LSB +: IMM_W];

    assign host_preg = wb_adr[PREG_W-1:0];
    assign wb_ack    = (state == ACK);

    always_comb begin
        rd_data = '0;
        if (is_value) begin
            rd_data = host_value;
        end else if (is_status) begin
            rd_data[STATUS_PEND_BIT] = host_pending;
            rd_data[TAG_W-1:0]       = host_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (uop_wr) begin
                        state <= uop_ready ? ACK : WAIT_SLOT;
                    end else if (req) begin
                        state <= ACK;
                    end
                end
                WAIT_SLOT: begin
                    if (!req) begin
                        state <= IDLE;
                    end else if (uop_ready) begin
                        state <= ACK;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sampled in the strobe cycle from stored register file state
    always_ff @(posedge clk) begin
        if (state == IDLE && req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: ooo_pkg.sv
/* Shared widths, opcode enum, micro-op field positions and Wishbone address map
   for the out-of-order execution slice */
package ooo_pkg;

    // Register file geometry
    localparam int PREG_COUNT = 32;
    localparam int PREG_W     = 5;
    localparam int DATA_W     = 32;
    localparam int TAG_W      = 3;

    // Multiplier latency from dispatch to its writeback lane
    localparam int MUL_STAGES = 3;

    localparam int OP_W  = 3;
    localparam int IMM_W = 14;

    typedef enum logic [OP_W-1:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_t;

    // Micro-op word layout
    localparam int UOP_OP_LSB  = 29;
    localparam int UOP_RD_LSB  = 24;
    localparam int UOP_RS1_LSB = 19;
    localparam int UOP_RS2_LSB = 14;
    localparam int UOP_IMM_LSB = 0;

    // Wishbone word addresses
    localparam int         ADR_W           = 8;
    localparam logic [7:0] ADR_UOP         = 8'h00;
    localparam logic [7:0] ADR_VALUE_BASE  = 8'h40;
    localparam logic [7:0] ADR_STATUS_BASE = 8'h80;

    // Pending flag of the status word, with the tag in the low bits
    localparam int STATUS_PEND_BIT = 8;

endpackage
